//--- all.f
source/axil_pkg.sv
source/ranker_pkg.sv
source/reg_bus_if.sv
source/axil_control.sv
source/ranker_regs.sv
source/ranker_core.sv
source/ranker_top.sv
verification/ranker_properties.sv
verification/ranker_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ranker_tb -f all.f -o ranker_sim

./obj_dir/ranker_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
grep -q "All tests passed" sim.log

//--- source/axil_control.sv
`timescale 1ns/1ps

module axil_control import axil_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [data_width-1:0] wdata,
    input  logic [strb_width-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output resp_t                 bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [addr_width-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [data_width-1:0] rdata,
    output resp_t                 rresp,
    output logic                  rvalid,
    input  logic                  rready,
    reg_bus_if.control            bus
);

    wr_state_t             wr_state;
    rd_state_t             rd_state;
    logic [addr_width-1:0] aw_addr;

    //////////////////////////////
    // write channel
    assign awready = (wr_state == wr_idle);
    assign wready  = (wr_state == wr_data);
    assign bvalid  = (wr_state == wr_resp);

    assign bus.wr_en   = wready && wvalid;
    assign bus.wr_addr = aw_addr;
    assign bus.wr_data = wdata;
    assign bus.wr_strb = wstrb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: if (awvalid) wr_state <= wr_data;
                wr_data: if (wvalid) wr_state <= wr_resp;
                wr_resp: if (bready) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // address and response only move on a handshake, so they hold under back-pressure
    always_ff @(posedge clk) begin
        if (awready && awvalid) begin
            aw_addr <= awaddr;
        end
        if (bus.wr_en) begin
            bresp <= bus.wr_hit ? resp_okay : resp_slverr;
        end
    end

    //////////////////////////////
    // read channel
    assign arready = (rd_state == rd_idle);
    assign rvalid  = (rd_state == rd_resp);

    assign bus.rd_en   = arready && arvalid;
    assign bus.rd_addr = araddr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (arvalid) rd_state <= rd_resp;
                rd_resp: if (rready) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            rdata <= bus.rd_data;
            rresp <= bus.rd_hit ? resp_okay : resp_slverr;
        end
    end

endmodule

//--- source/axil_pkg.sv
package axil_pkg;

    localparam int addr_width = 16;
    localparam int data_width = 32;
    localparam int strb_width = 4;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // write channel takes the address first, then the data
    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_t;

    typedef enum logic {
        rd_idle,
        rd_resp
    } rd_state_t;

endpackage

//--- source/ranker_core.sv
`timescale 1ns/1ps

module ranker_core import ranker_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    input  key_t   query_hash,
    input  key_t   segment_id,
    input  key_t   segment_pos,
    input  score_t base_score,
    output logic   out_valid,
    output score_t final_score,
    output rank_t  rank
);

    // 0 to 64 matching bits
    logic [6:0]  match_count;
    logic        s1_valid;
    logic [6:0]  s1_match;
    score_t      s1_base;
    logic [15:0] s1_pos;

    assign match_count = 7'($countones(~(query_hash ^ segment_id)));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    //////////////////////////////
    // stage 1 holds the count, stage 2 the score
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_match <= match_count;
            s1_base  <= base_score;
            s1_pos   <= segment_pos[15:0];
        end
        if (s1_valid) begin
            // wraps modulo 2^32
            final_score <= s1_base + (score_t'(s1_match) << 8) - score_t'(s1_pos);
            rank        <= rank_t'(s1_match);
        end
    end

endmodule

//--- source/ranker_pkg.sv
package ranker_pkg;

    //////////////////////////////
    // register map
    localparam logic [15:0] addr_control = 16'h0000;
    localparam logic [15:0] addr_status  = 16'h0004;
    localparam logic [15:0] addr_config  = 16'h0008;
    localparam logic [15:0] addr_hash_lo = 16'h0020;
    localparam logic [15:0] addr_hash_hi = 16'h0024;
    localparam logic [15:0] addr_seg_lo  = 16'h0028;
    localparam logic [15:0] addr_seg_hi  = 16'h002C;
    localparam logic [15:0] addr_pos_lo  = 16'h0030;
    localparam logic [15:0] addr_pos_hi  = 16'h0034;
    localparam logic [15:0] addr_score   = 16'h0038;
    localparam logic [15:0] addr_result  = 16'h003C;

    //////////////////////////////
    // bit fields
    localparam int ctrl_valid_bit  = 1;
    localparam int status_done_bit = 1;
    // rank occupies the upper half of status
    localparam int status_rank_lo  = 16;

    typedef logic [63:0] key_t;
    typedef logic [31:0] score_t;
    typedef logic [15:0] rank_t;

endpackage

//--- source/ranker_regs.sv
`timescale 1ns/1ps

module ranker_regs import axil_pkg::*, ranker_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    reg_bus_if.bank bus,
    output key_t   query_hash,
    output key_t   segment_id,
    output key_t   segment_pos,
    output score_t base_score,
    output logic   run,
    input  logic   out_valid,
    input  score_t final_score,
    input  rank_t  rank
);

    logic [data_width-1:0] control_reg;
    logic [data_width-1:0] config_reg;
    logic [data_width-1:0] status_reg;
    score_t                result_reg;
    key_t                  hash_reg;
    key_t                  seg_reg;
    key_t                  pos_reg;
    score_t                score_reg;

    // byte lanes without a strobe keep their old value
    function automatic logic [data_width-1:0] merge(
        input logic [data_width-1:0] old_value,
        input logic [data_width-1:0] new_value,
        input logic [strb_width-1:0] strb
    );
        logic [data_width-1:0] merged;
        merged = old_value;
        for (int i = 0; i < strb_width; i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_value[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    //////////////////////////////
    // write decode
    always_comb begin
        case (bus.wr_addr)
            addr_control, addr_config, addr_hash_lo, addr_hash_hi, addr_seg_lo,
            addr_seg_hi, addr_pos_lo, addr_pos_hi, addr_score: bus.wr_hit = 1'b1;
            default: bus.wr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            control_reg <= '0;
            config_reg  <= '0;
            hash_reg    <= '0;
            seg_reg     <= '0;
            pos_reg     <= '0;
            score_reg   <= '0;
        end else if (bus.wr_en) begin
            case (bus.wr_addr)
                addr_control: control_reg <= merge(control_reg, bus.wr_data, bus.wr_strb);
                addr_config:  config_reg  <= merge(config_reg, bus.wr_data, bus.wr_strb);
                addr_hash_lo: hash_reg[data_width-1:0] <=
                    merge(hash_reg[data_width-1:0], bus.wr_data, bus.wr_strb);
                addr_hash_hi: hash_reg[2*data_width-1:data_width] <=
                    merge(hash_reg[2*data_width-1:data_width], bus.wr_data, bus.wr_strb);
                addr_seg_lo:  seg_reg[data_width-1:0] <=
                    merge(seg_reg[data_width-1:0], bus.wr_data, bus.wr_strb);
                addr_seg_hi:  seg_reg[2*data_width-1:data_width] <=
                    merge(seg_reg[2*data_width-1:data_width], bus.wr_data, bus.wr_strb);
                addr_pos_lo:  pos_reg[data_width-1:0] <=
                    merge(pos_reg[data_width-1:0], bus.wr_data, bus.wr_strb);
                addr_pos_hi:  pos_reg[2*data_width-1:data_width] <=
                    merge(pos_reg[2*data_width-1:data_width], bus.wr_data, bus.wr_strb);
                addr_score:   score_reg <= merge(score_reg, bus.wr_data, bus.wr_strb);
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // result capture, done stays set until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status_reg <= '0;
            result_reg <= '0;
        end else if (out_valid) begin
            result_reg                       <= final_score;
            status_reg[status_done_bit]      <= 1'b1;
            status_reg[status_rank_lo +: 16] <= rank;
        end
    end

    // read mux, unmapped addresses return zero
    always_comb begin
        bus.rd_hit = 1'b1;
        case (bus.rd_addr)
            addr_control: bus.rd_data = control_reg;
            addr_status:  bus.rd_data = status_reg;
            addr_config:  bus.rd_data = config_reg;
            addr_hash_lo: bus.rd_data = hash_reg[data_width-1:0];
            addr_hash_hi: bus.rd_data = hash_reg[2*data_width-1:data_width];
            addr_seg_lo:  bus.rd_data = seg_reg[data_width-1:0];
            addr_seg_hi:  bus.rd_data = seg_reg[2*data_width-1:data_width];
            addr_pos_lo:  bus.rd_data = pos_reg[data_width-1:0];
            addr_pos_hi:  bus.rd_data = pos_reg[2*data_width-1:data_width];
            addr_score:   bus.rd_data = score_reg;
            addr_result:  bus.rd_data = result_reg;
            default: begin
                bus.rd_hit  = 1'b0;
                bus.rd_data = '0;
            end
        endcase
    end

    assign query_hash  = hash_reg;
    assign segment_id  = seg_reg;
    assign segment_pos = pos_reg;
    assign base_score  = score_reg;
    assign run         = control_reg[ctrl_valid_bit];

endmodule

//--- source/ranker_top.sv
`timescale 1ns/1ps

module ranker_top import axil_pkg::*, ranker_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [data_width-1:0] wdata,
    input  logic [strb_width-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output resp_t                 bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [addr_width-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [data_width-1:0] rdata,
    output resp_t                 rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  irq_out
);

    key_t   query_hash;
    key_t   segment_id;
    key_t   segment_pos;
    score_t base_score;
    score_t final_score;
    rank_t  rank;
    logic   run;

    reg_bus_if bus ();

    axil_control i_axil_control (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bus     (bus.control)
    );

    // the interrupt is the pipeline's result strobe
    ranker_regs i_ranker_regs (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus.bank),
        .query_hash  (query_hash),
        .segment_id  (segment_id),
        .segment_pos (segment_pos),
        .base_score  (base_score),
        .run         (run),
        .out_valid   (irq_out),
        .final_score (final_score),
        .rank        (rank)
    );

    ranker_core i_ranker_core (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (run),
        .query_hash  (query_hash),
        .segment_id  (segment_id),
        .segment_pos (segment_pos),
        .base_score  (base_score),
        .out_valid   (irq_out),
        .final_score (final_score),
        .rank        (rank)
    );

endmodule

//--- source/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if import axil_pkg::*; ();

    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_strb;
    logic                  wr_hit;

    logic                  rd_en;
    logic [addr_width-1:0] rd_addr;
    logic [data_width-1:0] rd_data;
    logic                  rd_hit;

    // hit and read data come back from the bank in the same cycle
    modport control (
        output wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        input  wr_hit, rd_hit, rd_data
    );

    modport bank (
        input  wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        output wr_hit, rd_hit, rd_data
    );

endinterface

//--- verification/ranker_properties.sv
`timescale 1ns/1ps

module ranker_properties import axil_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  awready,
    input logic                  bvalid,
    input logic                  bready,
    input resp_t                 bresp,
    input logic                  rvalid,
    input logic                  rready,
    input resp_t                 rresp,
    input logic [data_width-1:0] rdata
);

    // a response waits for its ready and does not change meanwhile
    b_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

    r_held: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
        else $error("read response dropped or changed before rready");

    // no new write address while a response is pending
    aw_blocked: assert property (@(posedge clk) disable iff (reset)
        bvalid |-> !awready)
        else $error("awready high while a write response is pending");

endmodule

bind axil_control ranker_properties i_ranker_properties (
    .clk     (clk),
    .reset   (reset),
    .awready (awready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rresp   (rresp),
    .rdata   (rdata)
);

//--- verification/ranker_tb.sv
`timescale 1ns/1ps

module ranker_tb import axil_pkg::*, ranker_pkg::*; ();

    localparam int max_cycles = 400 * 20;

    logic                  clk;
    logic                  reset;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    resp_t                 bresp;
    logic                  bvalid;
    logic                  bready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [data_width-1:0] rdata;
    resp_t                 rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  irq_out;

    logic [31:0] rng_state = 32'd59561;
    logic [31:0] shadow [16];
    int          cycle = 0;
    int          bvalid_cycle = 0;
    logic        irq_quiet = 1'b0;

    logic [15:0] rw_addrs [9] = '{addr_control, addr_config, addr_hash_lo, addr_hash_hi,
        addr_seg_lo, addr_seg_hi, addr_pos_lo, addr_pos_hi, addr_score};
    logic [15:0] unmapped [6] = '{16'h000C, 16'h0010, 16'h0014, 16'h001C, 16'h0040,
        16'h0FFC};

    ranker_top i_ranker_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            report_failure();
        end
    end

    //////////////////////////////
    // model and helpers
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic is_readable(input logic [15:0] addr);
        case (addr)
            addr_control, addr_status, addr_config, addr_hash_lo, addr_hash_hi, addr_seg_lo,
            addr_seg_hi, addr_pos_lo, addr_pos_hi, addr_score, addr_result: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_writable(input logic [15:0] addr);
        return is_readable(addr) && addr != addr_status && addr != addr_result;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                                input logic [31:0] new_value,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old_value;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) result[i*8 +: 8] = new_value[i*8 +: 8];
        end
        return result;
    endfunction

    function automatic int match_count(input key_t a, input key_t b);
        int n;
        n = 0;
        for (int i = 0; i < 64; i++) begin
            if (a[i] == b[i]) n++;
        end
        return n;
    endfunction

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // irq_out must stay low while no run is active
    always @(negedge clk) begin
        if (irq_quiet) check_value("irq_out", 32'(irq_out), 32'd0);
    end

    //////////////////////////////
    // bus tasks
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        resp_t exp_resp;
        resp_t first_resp;
        int    hold;
        exp_resp = is_writable(addr) ? resp_okay : resp_slverr;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        while (!awready) @(negedge clk);
        // data is only taken after the address
        check_value("wready", 32'(wready), 32'd0);
        @(negedge clk);
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        check_value("wready", 32'(wready), 32'd1);
        @(negedge clk);
        wvalid = 1'b0;
        while (!bvalid) @(negedge clk);
        bvalid_cycle = cycle;
        first_resp = bresp;
        hold = int'(next_random() % 32'd4);
        repeat (hold) begin
            @(negedge clk);
            check_value("bvalid", 32'(bvalid), 32'd1);
            check_value("bresp", 32'(bresp), 32'(first_resp));
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_value("bresp", 32'(first_resp), 32'(exp_resp));
        if (is_writable(addr)) shadow[addr[5:2]] = merge_bytes(shadow[addr[5:2]], data, strb);
    endtask

    task automatic read_reg(input logic [15:0] addr);
        logic [31:0] exp_data;
        resp_t       exp_resp;
        logic [31:0] first_data;
        resp_t       first_resp;
        int          hold;
        exp_data = is_readable(addr) ? shadow[addr[5:2]] : 32'h0;
        exp_resp = is_readable(addr) ? resp_okay : resp_slverr;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        first_data = rdata;
        first_resp = rresp;
        hold = int'(next_random() % 32'd4);
        repeat (hold) begin
            @(negedge clk);
            check_value("rvalid", 32'(rvalid), 32'd1);
            check_value("rdata", rdata, first_data);
            check_value("rresp", 32'(rresp), 32'(first_resp));
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_value("rdata", first_data, exp_data);
        check_value("rresp", 32'(first_resp), 32'(exp_resp));
    endtask

    task automatic read_all_mapped();
        for (int i = 0; i < 16; i++) begin
            if (is_readable(16'(i * 4))) read_reg(16'(i * 4));
        end
    endtask

    // waits for irq_out to reach a level, at most 4 cycles after the last bvalid
    task automatic wait_irq(input logic level);
        while (irq_out !== level) begin
            assert (cycle - bvalid_cycle <= 4) else begin
                $display("irq_out did not follow the run bit within 4 cycles of bvalid");
                report_failure();
            end
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // test sequences
    task automatic random_writes(input int count);
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] r;
        for (int n = 0; n < count; n++) begin
            addr = rw_addrs[int'(next_random() % 32'd9)];
            data = next_random();
            r = next_random();
            if (addr == addr_control) data[ctrl_valid_bit] = 1'b0;
            write_reg(addr, data, r[3:0]);
            read_reg(addr);
        end
    endtask

    task automatic error_accesses();
        write_reg(addr_status, next_random(), 4'hf);
        write_reg(addr_result, next_random(), 4'hf);
        for (int i = 0; i < 6; i++) begin
            write_reg(unmapped[i], next_random(), 4'hf);
            read_reg(unmapped[i]);
        end
        read_reg(16'h8000 | 16'(next_random() % 32'h8000));
        read_all_mapped();
    endtask

    task automatic scoring_round(input int n);
        key_t   hash;
        key_t   seg;
        key_t   pos;
        score_t base;
        int     mc;
        hash = {next_random(), next_random()};
        case (n)
            0: seg = hash;
            1: seg = ~hash;
            // sparse masks push the match count toward the top of its range
            default: seg = hash ^ {next_random() & next_random(), next_random() & next_random()};
        endcase
        pos  = {next_random(), next_random()};
        base = next_random();
        write_reg(addr_hash_lo, hash[31:0], 4'hf);
        write_reg(addr_hash_hi, hash[63:32], 4'hf);
        write_reg(addr_seg_lo, seg[31:0], 4'hf);
        write_reg(addr_seg_hi, seg[63:32], 4'hf);
        write_reg(addr_pos_lo, pos[31:0], 4'hf);
        write_reg(addr_pos_hi, pos[63:32], 4'hf);
        write_reg(addr_score, base, 4'hf);
        mc = match_count(hash, seg);
        irq_quiet = 1'b0;
        write_reg(addr_control, shadow[addr_control[5:2]] | (32'd1 << ctrl_valid_bit), 4'hf);
        wait_irq(1'b1);
        write_reg(addr_control, shadow[addr_control[5:2]] & ~(32'd1 << ctrl_valid_bit), 4'hf);
        wait_irq(1'b0);
        irq_quiet = 1'b1;
        shadow[addr_result[5:2]] = base + score_t'(mc) * 32'd256 - {16'h0, pos[15:0]};
        shadow[addr_status[5:2]] = (32'(mc) << status_rank_lo) | (32'd1 << status_done_bit);
        read_reg(addr_result);
        read_reg(addr_status);
        read_reg(addr_control);
    endtask

    initial begin
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("awready", 32'(awready), 32'd1);
        check_value("arready", 32'(arready), 32'd1);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("irq_out", 32'(irq_out), 32'd0);
        irq_quiet = 1'b1;
        read_all_mapped();
        random_writes(60);
        read_all_mapped();
        error_accesses();
        for (int n = 0; n < 8; n++) begin
            scoring_round(n);
        end
        read_all_mapped();
        $display("All tests passed");
        $finish;
    end

endmodule
